/* Makefile */
TOP = tb_matrix_alu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o Vtb
	@out="$$(./obj_dir/Vtb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* all.f */
design/matrix_pkg.sv
design/alu_step_if.sv
design/alu_sequencer.sv
design/alu_datapath.sv
design/matrix_alu_top.sv
verif/tb_clock_gen.sv
verif/matrix_alu_assertions.sv
verif/tb_matrix_alu.sv

/* design/alu_datapath.sv */
/*
  Operand fetch, multiply-accumulate and saturating write of the result cells.
  ACC_W must hold MAX_DIM full-scale products without overflow.
  Result cells are zeroed on each accepted start and written one per step.
*/

`timescale 1ns/1ps

module alu_datapath #(
  parameter int ACC_W = 24
) (
  input  logic                clk,
  input  logic                rst_n,
  alu_step_if.dp              step,
  input  matrix_pkg::matrix_t a_i,
  input  matrix_pkg::matrix_t b_i,
  input  matrix_pkg::elem_t   scalar_i,
  output matrix_pkg::elem_t [matrix_pkg::MAX_DIM-1:0][matrix_pkg::MAX_DIM-1:0] cells_o
);
  import matrix_pkg::*;

  localparam logic signed [ACC_W-1:0] SAT_HI = ACC_W'((2 ** (ELEM_W - 1)) - 1);
  localparam logic signed [ACC_W-1:0] SAT_LO = -(SAT_HI + 1);

  logic signed [ACC_W-1:0] opa_q;
  logic signed [ACC_W-1:0] opb_q;
  logic signed [ACC_W-1:0] acc_q;
  logic signed [ACC_W-1:0] wr_val;
  logic                    fetch_en;

  function automatic logic signed [ACC_W-1:0] widen(input elem_t e);
    return ACC_W'(e);
  endfunction

  // Clamp to the signed element range
  function automatic elem_t saturate(input logic signed [ACC_W-1:0] v);
    if (v > SAT_HI) begin
      return SAT_HI[ELEM_W-1:0];
    end else if (v < SAT_LO) begin
      return SAT_LO[ELEM_W-1:0];
    end
    return v[ELEM_W-1:0];
  endfunction

  // No fetch in the multiply write cycle, k is past the last column there
  assign fetch_en = (step.phase == PH_FETCH) && !step.write_cell;

  // ----------------------------------------
  // Operand fetch
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      case (step.op)
        OP_ADD: begin
          opa_q <= widen(a_i.cells[step.row][step.col]);
          opb_q <= widen(b_i.cells[step.row][step.col]);
        end
        OP_SCALAR_MUL: begin
          opa_q <= widen(a_i.cells[step.row][step.col]);
          opb_q <= widen(scalar_i);
        end
        OP_TRANSPOSE: begin
          // Source indices swapped
          opa_q <= widen(a_i.cells[step.col][step.row]);
          opb_q <= '0;
        end
        OP_MAT_MUL: begin
          opa_q <= widen(a_i.cells[step.row][step.k]);
          opb_q <= widen(b_i.cells[step.k][step.col]);
        end
      endcase
    end
  end

  // ----------------------------------------
  // Execute
  // ----------------------------------------
  always_comb begin
    case (step.op)
      OP_ADD:        wr_val = opa_q + opb_q;
      OP_SCALAR_MUL: wr_val = opa_q * opb_q;
      OP_TRANSPOSE:  wr_val = opa_q;
      OP_MAT_MUL:    wr_val = acc_q;
    endcase
  end

  // Dot product accumulator, emptied after each written cell
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (step.clear || step.write_cell) begin
      acc_q <= '0;
    end else if (step.acc_step) begin
      acc_q <= acc_q + (opa_q * opb_q);
    end
  end

  always_ff @(posedge clk) begin
    if (step.clear) begin
      cells_o <= '0;
    end else if (step.write_cell) begin
      cells_o[step.row][step.col] <= saturate(wr_val);
    end
  end

endmodule

/* design/alu_sequencer.sv */
/*
  Control FSM of the matrix ALU with dimension check and loop counters.
  start_i is a level: it is taken only in idle and must stay high until done_o.
  cycle_cnt_o counts execute cycles only and is zero after a dimension error.
*/

`timescale 1ns/1ps

module alu_sequencer #(
  parameter int CYCLE_W = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  matrix_pkg::alu_op_e         op_i,
  input  matrix_pkg::matrix_t         a_i,
  input  matrix_pkg::matrix_t         b_i,
  alu_step_if.seq                     step,
  output logic [matrix_pkg::DIM_W-1:0] res_rows_o,
  output logic [matrix_pkg::DIM_W-1:0] res_cols_o,
  output logic                        done_o,
  output logic                        error_o,
  output logic                        result_valid_o,
  output logic [CYCLE_W-1:0]          cycle_cnt_o
);
  import matrix_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_DONE
  } alu_state_e;

  alu_state_e       state;
  alu_op_e          op_reg;
  step_phase_e      phase;

  logic [DIM_W-1:0] row_cnt;
  logic [DIM_W-1:0] col_cnt;
  logic [DIM_W-1:0] k_cnt;

  // Loop limits, rows and cols double as the result shape
  logic [DIM_W-1:0] lim_rows;
  logic [DIM_W-1:0] lim_cols;
  logic [DIM_W-1:0] lim_k;

  logic             accept;
  logic             in_exec;
  logic             write_now;
  logic             last_col;
  logic             last_row;

  // Shape of the operation about to start
  logic             dim_err;
  logic [DIM_W-1:0] nxt_rows;
  logic [DIM_W-1:0] nxt_cols;
  logic [DIM_W-1:0] nxt_k;

  // ----------------------------------------
  // Dimension check and loop limits
  // ----------------------------------------
  always_comb begin
    dim_err  = 1'b0;
    nxt_rows = a_i.rows;
    nxt_cols = a_i.cols;
    nxt_k    = '0;
    case (op_i)
      OP_ADD: begin
        dim_err = (a_i.rows != b_i.rows) || (a_i.cols != b_i.cols);
      end
      OP_SCALAR_MUL: begin
      end
      OP_TRANSPOSE: begin
        nxt_rows = a_i.cols;
        nxt_cols = a_i.rows;
      end
      OP_MAT_MUL: begin
        dim_err  = (a_i.cols != b_i.rows);
        nxt_cols = b_i.cols;
        nxt_k    = a_i.cols;
      end
    endcase
  end

  assign accept  = (state == ST_IDLE) && start_i;
  assign in_exec = (state == ST_EXEC);

  // Multiply writes once all K products are in, the rest after each fetch
  assign write_now = in_exec &&
                     ((op_reg == OP_MAT_MUL) ? (k_cnt == lim_k) : (phase == PH_EXEC));

  assign last_col = (col_cnt == lim_cols - 1'b1);
  assign last_row = (row_cnt == lim_rows - 1'b1);

  // ----------------------------------------
  // FSM and counters
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= ST_IDLE;
      op_reg         <= OP_ADD;
      phase          <= PH_FETCH;
      row_cnt        <= '0;
      col_cnt        <= '0;
      k_cnt          <= '0;
      lim_rows       <= '0;
      lim_cols       <= '0;
      lim_k          <= '0;
      done_o         <= 1'b0;
      error_o        <= 1'b0;
      result_valid_o <= 1'b0;
      cycle_cnt_o    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            op_reg         <= op_i;
            phase          <= PH_FETCH;
            row_cnt        <= '0;
            col_cnt        <= '0;
            k_cnt          <= '0;
            error_o        <= dim_err;
            result_valid_o <= 1'b0;
            cycle_cnt_o    <= '0;
            if (dim_err) begin
              lim_rows <= '0;
              lim_cols <= '0;
              lim_k    <= '0;
              state    <= ST_DONE;
            end else begin
              lim_rows <= nxt_rows;
              lim_cols <= nxt_cols;
              lim_k    <= nxt_k;
              state    <= ST_EXEC;
            end
          end
        end

        ST_EXEC: begin
          cycle_cnt_o <= cycle_cnt_o + CYCLE_W'(1);
          if (write_now) begin
            phase <= PH_FETCH;
            k_cnt <= '0;
            if (last_col) begin
              col_cnt <= '0;
              if (last_row) begin
                result_valid_o <= 1'b1;
                state          <= ST_DONE;
              end else begin
                row_cnt <= row_cnt + 1'b1;
              end
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end else if (phase == PH_FETCH) begin
            phase <= PH_EXEC;
          end else begin
            // Product accumulated, move to next inner index
            phase <= PH_FETCH;
            k_cnt <= k_cnt + 1'b1;
          end
        end

        ST_DONE: begin
          if (start_i) begin
            done_o <= 1'b1;
          end else begin
            done_o <= 1'b0;
            state  <= ST_IDLE;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // Step controls to the datapath
  assign step.op         = op_reg;
  assign step.row        = row_cnt;
  assign step.col        = col_cnt;
  assign step.k          = k_cnt;
  assign step.phase      = phase;
  assign step.acc_step   = in_exec && (op_reg == OP_MAT_MUL) && (phase == PH_EXEC) &&
                           (k_cnt != lim_k);
  assign step.write_cell = write_now;
  assign step.clear      = accept;

  assign res_rows_o = lim_rows;
  assign res_cols_o = lim_cols;

endmodule

/* design/alu_step_if.sv */
/*
  Per-cycle step controls from the sequencer to the datapath.
  All signals change with the sequencer state and are valid every cycle.
*/

`timescale 1ns/1ps

interface alu_step_if;
  import matrix_pkg::*;

  // Latched opcode of the running operation
  alu_op_e          op;

  // Loop indices
  logic [DIM_W-1:0] row;
  logic [DIM_W-1:0] col;
  logic [DIM_W-1:0] k;

  step_phase_e      phase;
  logic             acc_step;
  logic             write_cell;
  // High in the cycle a start is accepted
  logic             clear;

  modport seq (
    output op, row, col, k,
    output phase, acc_step, write_cell, clear
  );

  modport dp (
    input op, row, col, k,
    input phase, acc_step, write_cell, clear
  );

endinterface

/* design/matrix_alu_top.sv */
/*
  Multi-cycle matrix ALU: add, scalar multiply, transpose and matrix multiply.
  One operation at a time, started by a start_i level and ended by done_o.
  Inputs must stay stable from start until done_o rises.
*/

`timescale 1ns/1ps

module matrix_alu_top #(
  parameter int ACC_W   = 24,
  parameter int CYCLE_W = 32
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  matrix_pkg::alu_op_e op_i,
  input  matrix_pkg::matrix_t a_i,
  input  matrix_pkg::matrix_t b_i,
  input  matrix_pkg::elem_t   scalar_i,
  output logic                done_o,
  output logic                error_o,
  output matrix_pkg::matrix_t result_o,
  output logic                result_valid_o,
  output logic [CYCLE_W-1:0]  cycle_cnt_o
);
  import matrix_pkg::*;

  logic [DIM_W-1:0]                 res_rows;
  logic [DIM_W-1:0]                 res_cols;
  elem_t [MAX_DIM-1:0][MAX_DIM-1:0] res_cells;

  alu_step_if step_bus ();

  // Control and loop counters
  alu_sequencer #(
    .CYCLE_W (CYCLE_W)
  ) u_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .op_i           (op_i),
    .a_i            (a_i),
    .b_i            (b_i),
    .step           (step_bus.seq),
    .res_rows_o     (res_rows),
    .res_cols_o     (res_cols),
    .done_o         (done_o),
    .error_o        (error_o),
    .result_valid_o (result_valid_o),
    .cycle_cnt_o    (cycle_cnt_o)
  );

  // Fetch, MAC and result cells
  alu_datapath #(
    .ACC_W (ACC_W)
  ) u_dp (
    .clk      (clk),
    .rst_n    (rst_n),
    .step     (step_bus.dp),
    .a_i      (a_i),
    .b_i      (b_i),
    .scalar_i (scalar_i),
    .cells_o  (res_cells)
  );

  assign result_o = '{rows: res_rows, cols: res_cols, cells: res_cells};

endmodule

/* design/matrix_pkg.sv */
/*
  Shared sizes, element and matrix types and the opcode set of the matrix ALU.
  Matrices are at most MAX_DIM x MAX_DIM and cells outside rows/cols are don't-care.
  A dimension of zero or above MAX_DIM is not supported.
*/

package matrix_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  parameter int MAX_DIM = 4;
  // Holds 0 up to MAX_DIM
  parameter int DIM_W   = 3;
  parameter int ELEM_W  = 8;

  // ----------------------------------------
  // Data types
  // ----------------------------------------
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Cells indexed [row][col]
  typedef struct packed {
    logic [DIM_W-1:0]                    rows;
    logic [DIM_W-1:0]                    cols;
    elem_t [MAX_DIM-1:0][MAX_DIM-1:0]    cells;
  } matrix_t;

  // ----------------------------------------
  // Control encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    OP_ADD,
    OP_SCALAR_MUL,
    OP_TRANSPOSE,
    OP_MAT_MUL
  } alu_op_e;

  // Operand fetch, then execute or accumulate
  typedef enum logic {
    PH_FETCH,
    PH_EXEC
  } step_phase_e;

endpackage

/* verif/matrix_alu_assertions.sv */
/*
  Control checks on the sequencer, bound into every alu_sequencer instance.
  fail_cnt holds the number of failed checks so far.
*/

`timescale 1ns/1ps

module matrix_alu_assertions #(
  parameter int CYCLE_W = 32
) (
  input logic               clk,
  input logic               rst_n,
  input logic               done_i,
  input logic               error_i,
  input logic               result_valid_i,
  input logic [CYCLE_W-1:0] cycle_cnt_i
);

  int unsigned fail_cnt = 0;

  // Outputs are cleared while reset is held
  reset_clear: assert property (@(posedge clk) !rst_n |-> !done_i && !error_i)
    else begin
      $error("done_o or error_o set during reset");
      fail_cnt++;
    end

  // Count is frozen once the operation has finished
  count_hold: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> $stable(cycle_cnt_i))
    else begin
      $error("cycle_cnt_o changed while done_o was high");
      fail_cnt++;
    end

  err_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    error_i |-> !result_valid_i)
    else begin
      $error("result_valid_o set together with error_o");
      fail_cnt++;
    end

endmodule

bind alu_sequencer matrix_alu_assertions #(
  .CYCLE_W (CYCLE_W)
) u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .done_i         (done_o),
  .error_i        (error_o),
  .result_valid_i (result_valid_o),
  .cycle_cnt_i    (cycle_cnt_o)
);

/* verif/tb_clock_gen.sv */
/*
  Free-running 4 ns clock and an active-low reset held for 16 cycles.
*/

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam realtime HALF_PERIOD = 2.0;
  localparam int      RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* verif/tb_matrix_alu.sv */
/*
  Table-driven testbench of the matrix ALU with an integer reference model.
  Random values come from $urandom seeded with 67.
  The run is bounded by a cycle limit derived from the worst-case test length.
*/

`timescale 1ns/1ps

module tb_matrix_alu;
  import matrix_pkg::*;

  localparam int NUM_TESTS = 8;
  // Reset plus a worst-case 4x4 multiply and margin per test
  localparam int LIMIT = 16 + NUM_TESTS * (MAX_DIM * MAX_DIM * (2 * MAX_DIM + 1) + 10);

  typedef struct packed {
    alu_op_e          op;
    logic [DIM_W-1:0] a_rows;
    logic [DIM_W-1:0] a_cols;
    logic [DIM_W-1:0] b_rows;
    logic [DIM_W-1:0] b_cols;
    logic             exp_err;
    logic             forced;
  } test_t;

  // ----------------------------------------
  // Test table
  // ----------------------------------------
  localparam test_t TESTS [NUM_TESTS] = '{
    '{OP_ADD,        3'd3, 3'd3, 3'd3, 3'd3, 1'b0, 1'b1},
    '{OP_ADD,        3'd2, 3'd3, 3'd3, 3'd2, 1'b1, 1'b0},
    '{OP_SCALAR_MUL, 3'd4, 3'd4, 3'd4, 3'd4, 1'b0, 1'b0},
    '{OP_TRANSPOSE,  3'd2, 3'd4, 3'd2, 3'd4, 1'b0, 1'b0},
    '{OP_MAT_MUL,    3'd3, 3'd2, 3'd2, 3'd4, 1'b0, 1'b0},
    '{OP_MAT_MUL,    3'd4, 3'd4, 3'd4, 3'd4, 1'b0, 1'b1},
    '{OP_MAT_MUL,    3'd2, 3'd3, 3'd2, 3'd2, 1'b1, 1'b0},
    '{OP_ADD,        3'd2, 3'd2, 3'd2, 3'd2, 1'b0, 1'b0}
  };

  string names [NUM_TESTS] = '{
    "add_extreme", "add_mismatch", "scalar_neg", "transpose_2x4",
    "matmul_3x2x4", "matmul_extreme", "matmul_mismatch", "add_after_error"
  };

  logic              clk;
  logic              rst_n;
  logic              start_i;
  alu_op_e           op_i;
  matrix_t           a_i;
  matrix_t           b_i;
  elem_t             scalar_i;
  logic              done_o;
  logic              error_o;
  matrix_t           result_o;
  logic              result_valid_o;
  logic [31:0]       cycle_cnt_o;

  string             cur_name;
  int                test_errs;
  int                failed_tests = 0;
  int unsigned       cycle_count = 0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  matrix_alu_top #(
    .ACC_W   (24),
    .CYCLE_W (32)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .op_i           (op_i),
    .a_i            (a_i),
    .b_i            (b_i),
    .scalar_i       (scalar_i),
    .done_o         (done_o),
    .error_o        (error_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .cycle_cnt_o    (cycle_cnt_o)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int sval(input elem_t e);
    return int'(e);
  endfunction

  function automatic int clamp(input int v);
    if (v > 127) begin
      return 127;
    end else if (v < -128) begin
      return -128;
    end
    return v;
  endfunction

  function automatic matrix_t expected_result(input alu_op_e op, input matrix_t a,
                                              input matrix_t b, input elem_t s);
    matrix_t r;
    int      acc;
    r = '0;
    r.rows = (op == OP_TRANSPOSE) ? a.cols : a.rows;
    r.cols = (op == OP_TRANSPOSE) ? a.rows : ((op == OP_MAT_MUL) ? b.cols : a.cols);
    for (int i = 0; i < int'(r.rows); i++) begin
      for (int j = 0; j < int'(r.cols); j++) begin
        acc = 0;
        case (op)
          OP_ADD:        acc = sval(a.cells[i][j]) + sval(b.cells[i][j]);
          OP_SCALAR_MUL: acc = sval(a.cells[i][j]) * sval(s);
          OP_TRANSPOSE:  acc = sval(a.cells[j][i]);
          OP_MAT_MUL: begin
            for (int k = 0; k < int'(a.cols); k++) begin
              acc += sval(a.cells[i][k]) * sval(b.cells[k][j]);
            end
          end
        endcase
        r.cells[i][j] = elem_t'(clamp(acc));
      end
    end
    return r;
  endfunction

  // Whole array filled, cells outside the shape are don't-care
  function automatic matrix_t fill_matrix(input int rows, input int cols, input bit forced);
    matrix_t m;
    int      extremes [4] = '{100, -100, 127, -127};
    m.rows = DIM_W'(rows);
    m.cols = DIM_W'(cols);
    for (int i = 0; i < MAX_DIM; i++) begin
      for (int j = 0; j < MAX_DIM; j++) begin
        if (forced) begin
          m.cells[i][j] = elem_t'(extremes[$urandom_range(3)]);
        end else begin
          m.cells[i][j] = elem_t'($urandom);
        end
      end
    end
    return m;
  endfunction

  task automatic check_value(input string what, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("** Error %s: %s expected %0d actual %0d", cur_name, what, exp_v, act_v);
      test_errs++;
    end
  endtask

  // ----------------------------------------
  // One table entry
  // ----------------------------------------
  task automatic run_test(input int t);
    matrix_t a;
    matrix_t b;
    matrix_t exp_m;
    elem_t   s;
    int      exp_cycles;
    bit      err;
    cur_name  = names[t];
    test_errs = 0;
    err = TESTS[t].exp_err;
    a = fill_matrix(int'(TESTS[t].a_rows), int'(TESTS[t].a_cols), TESTS[t].forced);
    b = fill_matrix(int'(TESTS[t].b_rows), int'(TESTS[t].b_cols), TESTS[t].forced);
    if (TESTS[t].op == OP_SCALAR_MUL) begin
      s = elem_t'(-1 - int'($urandom_range(127)));
    end else begin
      s = elem_t'($urandom);
    end
    exp_m = expected_result(TESTS[t].op, a, b, s);
    if (err) begin
      exp_cycles = 0;
    end else if (TESTS[t].op == OP_MAT_MUL) begin
      exp_cycles = int'(exp_m.rows) * int'(exp_m.cols) * (2 * int'(a.cols) + 1);
    end else begin
      exp_cycles = int'(exp_m.rows) * int'(exp_m.cols) * 2;
    end

    @(posedge clk);
    op_i     <= TESTS[t].op;
    a_i      <= a;
    b_i      <= b;
    scalar_i <= s;
    start_i  <= 1'b1;
    @(negedge clk);
    while (done_o !== 1'b1) @(negedge clk);

    check_value("error_o", int'(err), int'(error_o));
    check_value("result_valid_o", int'(!err), int'(result_valid_o));
    check_value("cycle_cnt_o", exp_cycles, int'(cycle_cnt_o));
    if (!err) begin
      check_value("rows", int'(exp_m.rows), int'(result_o.rows));
      check_value("cols", int'(exp_m.cols), int'(result_o.cols));
      for (int i = 0; i < int'(exp_m.rows); i++) begin
        for (int j = 0; j < int'(exp_m.cols); j++) begin
          check_value($sformatf("cell[%0d][%0d]", i, j), sval(exp_m.cells[i][j]),
                      sval(result_o.cells[i][j]));
        end
      end
    end

    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    while (done_o !== 1'b0) @(negedge clk);

    if (test_errs != 0) begin
      failed_tests++;
    end
    $display("Test %-16s %s (%0d errors)", cur_name, (test_errs == 0) ? "ok" : "bad",
             test_errs);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(67));
    start_i  <= 1'b0;
    op_i     <= OP_ADD;
    a_i      <= '0;
    b_i      <= '0;
    scalar_i <= '0;
    while (rst_n !== 1'b1) @(posedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d", NUM_TESTS,
             NUM_TESTS - failed_tests, failed_tests, UUT.u_seq.u_sva.fail_cnt);
    if (failed_tests == 0 && UUT.u_seq.u_sva.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
